// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vcore testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --top-module tb_vcore \
    -f tb.f -Mdir "$build_dir" -o sim_vcore
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_vcore" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log_file"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$log_file"; then
    echo "no pass line found in $log_file"
    exit 1
fi
exit 0

// File: tb.f
verilog/vcore_pkg.sv
verilog/instruction_decode_unit.sv
verilog/register_files.sv
verilog/execute_lanes.sv
verilog/issue_sequencer.sv
verilog/mem_arbiter.sv
verilog/data_memory.sv
verilog/vcore_top.sv
verification/tb_vcore.sv

// File: verification/tb_vcore.sv
`timescale 1ns/100ps

module tb_vcore;
    import vcore_pkg::*;

    localparam int addr_w       = 6;
    localparam int n_tests      = 22;
    localparam int n_preload    = 4;
    localparam int n_host_reads = 12;
    localparam int n_readback   = 3;
    // 40 cycles for every entry of every table, plus reset
    localparam int timeout_cycles =
        40 * (n_tests + n_preload + n_host_reads + n_readback) + 10;

    // one instruction and the result it must produce
    typedef struct packed {
        instr_t instr;
        logic   is_vector;
        word_t  scalar;
        vec_t   vector;
    } entry_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        vec_t              data;
    } mem_word_t;

    logic     clk          = 1'b0;
    logic     reset        = 1'b1;
    logic     instr_valid  = 1'b0;
    instr_t   instr        = '0;
    logic     result_ready = 1'b0;
    logic     host_valid   = 1'b0;
    mem_req_t host_req     = '0;
    logic     instr_ready;
    logic     result_valid;
    result_t  result;
    logic     host_ready;
    logic     host_rsp_valid;
    mem_rsp_t host_rsp;

    logic [31:0] lfsr = 32'hba44_92b9;
    entry_t      tests [n_tests];
    mem_word_t   preload [n_preload];
    mem_word_t   readback [n_readback];
    int          errors     = 0;
    int          checks     = 0;
    int          done_tests = 0;

    vcore_top #(.addr_w(addr_w)) dut (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr          (instr),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result         (result),
        .host_valid     (host_valid),
        .host_ready     (host_ready),
        .host_req       (host_req),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp       (host_rsp)
    );

    always #10 clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr bit per cycle decides result back-pressure
    always @(posedge clk) begin
        if (reset) begin
            result_ready <= 1'b0;
        end else begin
            lfsr = lfsr_step(lfsr);
            result_ready <= lfsr[0];
        end
    end

    function automatic entry_t make_entry(logic [5:0] opcode, logic [1:0] imm,
                                          logic [2:0] rd, logic [2:0] rs1, logic [2:0] rs2,
                                          logic is_vector, word_t scalar, vec_t vector);
        entry_t e;
        e.instr.opcode = opcode;
        e.instr.imm    = imm;
        e.instr.rd     = rd;
        e.instr.rs1    = rs1;
        e.instr.rs2    = rs2;
        e.is_vector    = is_vector;
        e.scalar       = scalar;
        e.vector       = vector;
        return e;
    endfunction

    // lanes written as {lane3, lane2, lane1, lane0}
    task automatic fill_tables();
        preload[0]  = '{addr: 6'd0, data: {16'h0004, 16'h0003, 16'h0002, 16'h0001}};
        preload[1]  = '{addr: 6'd1, data: {16'h1000, 16'h0300, 16'h0020, 16'hffff}};
        preload[2]  = '{addr: 6'd2, data: {16'h0010, 16'h0020, 16'h0030, 16'h0040}};
        preload[3]  = '{addr: 6'd9, data: {16'haaaa, 16'hbbbb, 16'hcccc, 16'hdddd}};
        // addr 9 keeps lanes 3..1 after the scalar store
        readback[0] = '{addr: 6'd7, data: {16'h0044, 16'h0043, 16'hffc2, 16'h0041}};
        readback[1] = '{addr: 6'd9, data: {16'haaaa, 16'hbbbb, 16'hcccc, 16'h121f}};
        readback[2] = '{addr: 6'd0, data: {16'h0004, 16'h0003, 16'h0002, 16'h0001}};

        // v1 = mem[0], s1 = 1, v2 = mem[1]
        tests[0]  = make_entry(op_load_v, 2'd0, 3'd1, 3'd0, 3'd0, 1'b1, 16'h0,
                               {16'h0004, 16'h0003, 16'h0002, 16'h0001});
        tests[1]  = make_entry(op_int_addi, 2'd0, 3'd1, 3'd0, 3'd1, 1'b0, 16'h0001, '0);
        tests[2]  = make_entry(op_load_v, 2'd0, 3'd2, 3'd1, 3'd0, 1'b1, 16'h0,
                               {16'h1000, 16'h0300, 16'h0020, 16'hffff});
        // lane 0 wraps to zero
        tests[3]  = make_entry(op_vv_add, 2'd0, 3'd3, 3'd1, 3'd2, 1'b1, 16'h0,
                               {16'h1004, 16'h0303, 16'h0022, 16'h0000});
        tests[4]  = make_entry(op_vv_sub, 2'd0, 3'd4, 3'd2, 3'd1, 1'b1, 16'h0,
                               {16'h0ffc, 16'h02fd, 16'h001e, 16'hfffe});
        // s2 = 2, then s3 = lane 0 of mem[2]
        tests[5]  = make_entry(op_int_addi, 2'd0, 3'd2, 3'd0, 3'd2, 1'b0, 16'h0002, '0);
        tests[6]  = make_entry(op_load_s, 2'd0, 3'd3, 3'd2, 3'd0, 1'b0, 16'h0040, '0);
        // scalar 0x40 on every lane
        tests[7]  = make_entry(op_vf_add, 2'd0, 3'd5, 3'd1, 3'd3, 1'b1, 16'h0,
                               {16'h0044, 16'h0043, 16'h0042, 16'h0041});
        tests[8]  = make_entry(op_vf_sub, 2'd0, 3'd6, 3'd2, 3'd3, 1'b1, 16'h0,
                               {16'h0fc0, 16'h02c0, 16'hffe0, 16'hffbf});
        tests[9]  = make_entry(op_int_add, 2'd0, 3'd4, 3'd3, 3'd2, 1'b0, 16'h0042, '0);
        tests[10] = make_entry(op_int_sub, 2'd0, 3'd5, 3'd2, 3'd3, 1'b0, 16'hffc2, '0);
        // rs2 field is the immediate, 0x42 + 7
        tests[11] = make_entry(op_int_addi, 2'd0, 3'd6, 3'd4, 3'd7, 1'b0, 16'h0049, '0);
        tests[12] = make_entry(op_lane_get, 2'd2, 3'd7, 3'd2, 3'd0, 1'b0, 16'h0300, '0);
        tests[13] = make_entry(op_lane_get, 2'd0, 3'd7, 3'd4, 3'd0, 1'b0, 16'hfffe, '0);
        // s5 into lane 1 of v5, then v5 + v0 shows the whole register
        tests[14] = make_entry(op_lane_put, 2'd1, 3'd5, 3'd5, 3'd0, 1'b1, 16'h0,
                               {16'h0044, 16'h0043, 16'hffc2, 16'h0041});
        tests[15] = make_entry(op_vv_add, 2'd0, 3'd7, 3'd5, 3'd0, 1'b1, 16'h0,
                               {16'h0044, 16'h0043, 16'hffc2, 16'h0041});
        // 0x0000 + 0x0022 + 0x0303 + 0x1004
        tests[16] = make_entry(op_reduce, 2'd0, 3'd1, 3'd3, 3'd0, 1'b0, 16'h1329, '0);
        // sum of v6 wraps past 16 bits
        tests[17] = make_entry(op_reduce, 2'd0, 3'd1, 3'd6, 3'd0, 1'b0, 16'h121f, '0);
        tests[18] = make_entry(op_int_addi, 2'd0, 3'd2, 3'd0, 3'd7, 1'b0, 16'h0007, '0);
        // v5 to addr 7, s1 to lane 0 of addr 9 (s6 = 0x49)
        tests[19] = make_entry(op_store_v, 2'd0, 3'd0, 3'd2, 3'd5, 1'b1, 16'h0,
                               {16'h0044, 16'h0043, 16'hffc2, 16'h0041});
        tests[20] = make_entry(op_store_s, 2'd0, 3'd0, 3'd6, 3'd1, 1'b0, 16'h121f, '0);
        tests[21] = make_entry(op_load_v, 2'd0, 3'd0, 3'd6, 3'd0, 1'b1, 16'h0,
                               {16'haaaa, 16'hbbbb, 16'hcccc, 16'h121f});
    endtask

    // hold the request until the arbiter grants it
    task automatic host_transfer(input mem_req_t req);
        @(posedge clk);
        host_valid <= 1'b1;
        host_req   <= req;
        @(negedge clk);
        while (!host_ready)
            @(negedge clk);
        @(posedge clk);
        host_valid <= 1'b0;
    endtask

    task automatic host_write(input logic [addr_w-1:0] addr, input vec_t data);
        mem_req_t req;
        req.we    = 1'b1;
        req.addr  = mem_addr_w'(addr);
        req.wdata = data;
        req.mask  = 4'b1111;
        host_transfer(req);
    endtask

    task automatic host_read(input logic [addr_w-1:0] addr, output vec_t data);
        mem_req_t req;
        req      = '0;
        req.addr = mem_addr_w'(addr);
        host_transfer(req);
        // data due exactly one cycle after the grant
        @(negedge clk);
        if (!host_rsp_valid) begin
            $display("host read of address %h got no response one cycle after the grant",
                     addr);
            errors++;
        end
        data = host_rsp.rdata;
    endtask

    task automatic check_host_data(input string what, input logic [addr_w-1:0] addr,
                                   input vec_t got, input vec_t want);
        checks++;
        if (got !== want) begin
            $display("ERROR host_rsp.rdata (%s, addr %h): got %h, expected %h",
                     what, addr, got, want);
            errors++;
        end
        $display("%s addr %h: %s", what, addr, (got === want) ? "ok" : "mismatch");
    endtask

    task automatic drive_instructions();
        for (int k = 0; k < n_tests; k++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= tests[k].instr;
            @(negedge clk);
            while (!instr_ready)
                @(negedge clk);
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic check_result(input int k);
        entry_t want;
        int     bad;
        want = tests[k];
        bad  = 0;
        if (result.is_vector !== want.is_vector) begin
            $display("ERROR result.is_vector (test %0d): got %h, expected %h",
                     k, result.is_vector, want.is_vector);
            bad++;
        end
        if (result.rd !== want.instr.rd) begin
            $display("ERROR result.rd (test %0d): got %h, expected %h",
                     k, result.rd, want.instr.rd);
            bad++;
        end
        // only the field the instruction writes back is compared
        if (want.is_vector && result.vector !== want.vector) begin
            $display("ERROR result.vector (test %0d): got %h, expected %h",
                     k, result.vector, want.vector);
            bad++;
        end
        if (!want.is_vector && result.scalar !== want.scalar) begin
            $display("ERROR result.scalar (test %0d): got %h, expected %h",
                     k, result.scalar, want.scalar);
            bad++;
        end
        checks++;
        done_tests++;
        errors += bad;
        $display("test %0d opcode %b rd %0d: %s", k, want.instr.opcode, want.instr.rd,
                 (bad == 0) ? "ok" : "mismatch");
    endtask

    // results taken in order, one per accepted instruction
    task automatic collect_results();
        for (int k = 0; k < n_tests; k++) begin
            @(negedge clk);
            while (!(result_valid && result_ready))
                @(negedge clk);
            check_result(k);
            @(posedge clk);
        end
    endtask

    // host traffic on addresses the core only loads from
    task automatic contention_reads();
        vec_t data;
        int   idx;
        for (int i = 0; i < n_host_reads; i++) begin
            idx = i % 3;
            host_read(preload[idx].addr, data);
            check_host_data("host read under load", preload[idx].addr, data,
                            preload[idx].data);
        end
    endtask

    initial begin
        vec_t data;
        fill_tables();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // first cycle out of reset, everything still quiet
        @(negedge clk);
        checks++;
        if (instr_ready || result_valid || host_ready || host_rsp_valid) begin
            $display("an output was high in the first cycle after reset");
            errors++;
        end
        for (int i = 0; i < n_preload; i++)
            host_write(preload[i].addr, preload[i].data);
        fork
            drive_instructions();
            collect_results();
            contention_reads();
        join
        for (int i = 0; i < n_readback; i++) begin
            host_read(readback[i].addr, data);
            check_host_data("host readback", readback[i].addr, data, readback[i].data);
        end
        $display("instructions %0d of %0d, checks %0d, errors %0d",
                 done_tests, n_tests, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * 20);
        $display("the run timed out after %0d cycles without finishing", timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/100ps

module data_memory #(
    parameter int addr_w = 6
) (
    input  logic                clk,
    input  logic                mem_en,
    input  vcore_pkg::mem_req_t mem_req,
    output vcore_pkg::mem_rsp_t mem_rdata
);
    import vcore_pkg::*;

    vec_t              mem [2**addr_w];
    logic [addr_w-1:0] addr;

    assign addr = mem_req.addr[addr_w-1:0];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.we) begin
                // per-lane write mask
                for (int l = 0; l < lanes; l++) begin
                    if (mem_req.mask[l])
                        mem[addr][l] <= mem_req.wdata[l];
                end
            end else begin
                mem_rdata.rdata <= mem[addr];
            end
        end
    end

endmodule

// File: verilog/execute_lanes.sv
`timescale 1ns/100ps

module execute_lanes (
    input  vcore_pkg::ctrl_t  ctrl,
    input  logic [1:0]        imm,
    input  logic [2:0]        rs2,
    input  vcore_pkg::word_t  s_rs1,
    input  vcore_pkg::word_t  s_rs2,
    input  vcore_pkg::vec_t   v_rs1,
    input  vcore_pkg::vec_t   v_rs2,
    output vcore_pkg::word_t  scalar_result,
    output vcore_pkg::vec_t   vector_result,
    output logic [3:0]        lane_mask
);
    import vcore_pkg::*;

    word_t int_op2;
    word_t int_res;

    // int alu, op1 always scalar 1, immediate is the rs2 field
    assign int_op2 = ctrl.int_op2_sel ? word_t'(rs2) : s_rs2;
    assign int_res = !ctrl.int_en ? s_rs1 :
                     ctrl.sub     ? s_rs1 - int_op2 : s_rs1 + int_op2;

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        word_t op1;
        word_t op2;

        assign op1 = ctrl.lane_op1_sel[i] ? s_rs1 : v_rs1[i];

        if (i % 2 == 0) begin : g_even
            // 00 vector 2, 01 scalar 2, 10 next lane of vector 1
            always_comb begin
                case (ctrl.lane_even_op2_sel[i/2])
                    2'b01:   op2 = s_rs2;
                    2'b10:   op2 = v_rs1[i+1];
                    default: op2 = v_rs2[i];
                endcase
            end
        end else begin : g_odd
            assign op2 = ctrl.lane_odd_op2_sel[i/2] ? s_rs2 : v_rs2[i];
        end

        // disabled lanes pass op1 through
        assign vector_result[i] = !ctrl.lane_en[i] ? op1 :
                                  ctrl.sub         ? op1 - op2 : op1 + op2;
    end

    // reduce sums the two pairwise lane results, 16-bit wrap
    always_comb begin
        if (ctrl.reduce_en)
            scalar_result = vector_result[0] + vector_result[2];
        else if (ctrl.scalar_out_sel[2])
            scalar_result = vector_result[ctrl.scalar_out_sel[1:0]];
        else
            scalar_result = int_res;
    end

    // insert writes one lane, everything else writes all four
    assign lane_mask = (|ctrl.lane_op1_sel) ? 4'b0001 << imm : 4'b1111;

endmodule

// File: verilog/instruction_decode_unit.sv
`timescale 1ns/100ps

module instruction_decode_unit (
    input  vcore_pkg::instr_t instr,
    output vcore_pkg::ctrl_t  ctrl
);
    import vcore_pkg::*;

    logic [5:0] op;
    logic       class_vv;
    logic       class_vf;
    logic       class_addi;
    logic       class_int;
    logic       is_reduce;
    logic       is_get;
    logic       is_put;
    logic       is_mem;

    assign op = instr.opcode;

    // opcode classes
    assign class_vv   = (op[5:3] == 3'b000);
    assign class_vf   = (op[5:2] == 4'b0010);
    assign class_addi = (op[5:2] == 4'b0011);
    assign class_int  = (op[5:3] == 3'b011);
    assign is_reduce  = (op == op_reduce);
    assign is_get     = (op == op_lane_get);
    assign is_put     = (op == op_lane_put);
    assign is_mem     = is_mem_op(op);

    always_comb begin
        // defaults: immediate on int op2, all lanes from vectors
        ctrl = '0;
        ctrl.int_op2_sel = 1'b1;

        // only int-int takes scalar 2
        if (class_int)
            ctrl.int_op2_sel = 1'b0;
        ctrl.int_en = class_addi | class_int;

        // lane enables
        if (class_vv || class_vf)
            ctrl.lane_en = 4'b1111;
        else if (is_reduce)
            ctrl.lane_en = 4'b0101;

        // insert routes scalar 1 into the imm lane only
        if (is_put)
            ctrl.lane_op1_sel = 4'b0001 << instr.imm;

        // reduce pairs neighbour lanes, vf takes scalar 2
        if (is_reduce) begin
            ctrl.lane_even_op2_sel = {2'b10, 2'b10};
        end else if (class_vf) begin
            ctrl.lane_even_op2_sel = {2'b01, 2'b01};
            ctrl.lane_odd_op2_sel  = 2'b11;
        end

        // 000 int alu, 1xx lane alu
        if (is_get)
            ctrl.scalar_out_sel = {1'b1, instr.imm};

        // active, write, vector
        if (is_mem)
            ctrl.memory_op = {1'b1, op[4], op[1]};

        ctrl.reduce_en = is_reduce;
        // bit 0 only means subtract in the arithmetic classes
        ctrl.sub  = op[0] & (class_vv | class_vf | class_int);

        // writeback targets, loads by vector bit
        ctrl.s_we = class_addi | class_int | is_reduce | is_get
                  | (is_mem & ~op[4] & ~op[1]);
        ctrl.v_we = class_vv | class_vf | is_put
                  | (is_mem & ~op[4] & op[1]);
    end

endmodule

// File: verilog/issue_sequencer.sv
`timescale 1ns/100ps

module issue_sequencer #(
    parameter int addr_w = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  vcore_pkg::instr_t   instr,
    input  vcore_pkg::ctrl_t    ctrl,
    input  vcore_pkg::word_t    scalar_result,
    input  vcore_pkg::vec_t     vector_result,
    input  logic [3:0]          lane_mask,
    input  vcore_pkg::word_t    s_rs1,
    input  vcore_pkg::word_t    s_rs2,
    input  vcore_pkg::vec_t     v_rs2,
    input  logic                core_ready,
    input  logic                core_rsp_valid,
    input  vcore_pkg::mem_rsp_t core_rsp,
    input  logic                result_ready,
    output logic                instr_ready,
    output vcore_pkg::instr_t   held_instr,
    output logic                core_valid,
    output vcore_pkg::mem_req_t core_req,
    output logic                s_we,
    output logic                v_we,
    output logic [2:0]          wr_idx,
    output vcore_pkg::word_t    s_wdata,
    output vcore_pkg::vec_t     v_wdata,
    output logic [3:0]          v_lane_mask,
    output logic                result_valid,
    output vcore_pkg::result_t  result
);
    import vcore_pkg::*;

    typedef enum logic [1:0] {s_idle, s_mem, s_hold} state_t;

    state_t  state;
    state_t  state_next;
    logic    ready_q;
    logic    fresh;
    logic    req_sent;
    logic    mem_op;
    logic    load_op;
    vec_t    load_q;
    result_t res_comb;
    result_t result_q;

    assign mem_op  = ctrl.memory_op[2];
    assign load_op = mem_op & ~ctrl.memory_op[1];

    always_comb begin
        state_next = state;
        case (state)
            s_idle:
                if (instr_valid && instr_ready)
                    state_next = is_mem_op(instr.opcode) ? s_mem : s_hold;
            // store retires after its grant and load after its data
            s_mem:
                if ((core_valid && core_ready && !load_op) || core_rsp_valid)
                    state_next = s_hold;
            s_hold:
                if (result_ready)
                    state_next = s_idle;
            default:
                state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_idle;
            ready_q  <= 1'b0;
            fresh    <= 1'b0;
            req_sent <= 1'b0;
        end else begin
            state    <= state_next;
            ready_q  <= (state_next == s_idle);
            // first cycle of hold does writeback
            fresh    <= (state != s_hold) && (state_next == s_hold);
            req_sent <= (state_next == s_mem) && (req_sent || (core_valid && core_ready));
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready)
            held_instr <= instr;
        if (core_rsp_valid)
            load_q <= core_rsp.rdata;
        if (fresh)
            result_q <= res_comb;
    end

    assign instr_ready = ready_q;

    // memory request addressed by scalar 1
    assign core_valid    = (state == s_mem) && !req_sent;
    assign core_req.we   = ctrl.memory_op[1];
    assign core_req.addr = mem_addr_w'(s_rs1[addr_w-1:0]);
    assign core_req.wdata = ctrl.memory_op[0] ? v_rs2 : {lanes{s_rs2}};
    assign core_req.mask = ctrl.memory_op[0] ? 4'b1111 : 4'b0001;

    always_comb begin
        res_comb.is_vector = mem_op ? ctrl.memory_op[0] : ctrl.v_we;
        res_comb.rd        = held_instr.rd;
        if (load_op) begin
            // scalar load returns lane 0
            res_comb.scalar = load_q[0];
            res_comb.vector = load_q;
        end else if (mem_op) begin
            res_comb.scalar = s_rs2;
            res_comb.vector = v_rs2;
        end else begin
            res_comb.scalar = scalar_result;
            res_comb.vector = vector_result;
        end
    end

    // writeback only in the first hold cycle
    assign s_we        = fresh & ctrl.s_we;
    assign v_we        = fresh & ctrl.v_we;
    assign wr_idx      = held_instr.rd;
    assign s_wdata     = res_comb.scalar;
    assign v_wdata     = res_comb.vector;
    assign v_lane_mask = lane_mask;

    // registers may change after writeback, so later cycles show the copy
    assign result_valid = (state == s_hold);
    assign result       = fresh ? res_comb : result_q;

    // never offer a new slot while a result is pending
    a_ready_vs_result: assert property (@(posedge clk) disable iff (reset)
        !(result_valid && instr_ready));

    // a stalled result stays put until taken
    a_result_stable: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter #(
    parameter int addr_w = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                core_valid,
    input  vcore_pkg::mem_req_t core_req,
    input  logic                host_valid,
    input  vcore_pkg::mem_req_t host_req,
    output logic                core_ready,
    output logic                core_rsp_valid,
    output vcore_pkg::mem_rsp_t core_rsp,
    output logic                host_ready,
    output logic                host_rsp_valid,
    output vcore_pkg::mem_rsp_t host_rsp,
    output logic                mem_en,
    output vcore_pkg::mem_req_t mem_req,
    input  vcore_pkg::mem_rsp_t mem_rdata
);
    import vcore_pkg::*;

    logic     last_core;
    mem_req_t sel_req;

    // round robin where the side not granted last wins a tie
    assign core_ready = core_valid && (!host_valid || !last_core);
    assign host_ready = host_valid && (!core_valid || last_core);

    assign mem_en  = core_ready || host_ready;
    assign sel_req = host_ready ? host_req : core_req;

    always_comb begin
        mem_req      = sel_req;
        // fold address into memory depth
        mem_req.addr = mem_addr_w'(sel_req.addr[addr_w-1:0]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_core      <= 1'b0;
            core_rsp_valid <= 1'b0;
            host_rsp_valid <= 1'b0;
        end else begin
            if (core_ready)
                last_core <= 1'b1;
            else if (host_ready)
                last_core <= 1'b0;
            // read data owner one cycle behind the grant
            core_rsp_valid <= core_ready && !core_req.we;
            host_rsp_valid <= host_ready && !host_req.we;
        end
    end

    // both sides see the same read bus
    assign core_rsp = mem_rdata;
    assign host_rsp = mem_rdata;

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(core_ready && host_ready));

    // a core request that loses arbitration waits unchanged
    a_core_hold: assert property (@(posedge clk) disable iff (reset)
        core_valid && !core_ready |=> core_valid && $stable(core_req));

endmodule

// File: verilog/register_files.sv
`timescale 1ns/100ps

module register_files (
    input  logic              clk,
    input  logic              reset,
    input  logic [2:0]        rs1,
    input  logic [2:0]        rs2,
    input  logic              s_we,
    input  logic              v_we,
    input  logic [2:0]        wr_idx,
    input  vcore_pkg::word_t  s_wdata,
    input  vcore_pkg::vec_t   v_wdata,
    input  logic [3:0]        v_lane_mask,
    output vcore_pkg::word_t  s_rs1,
    output vcore_pkg::word_t  s_rs2,
    output vcore_pkg::vec_t   v_rs1,
    output vcore_pkg::vec_t   v_rs2
);
    import vcore_pkg::*;

    localparam int regs = 2 ** reg_idx_w;

    word_t s_regs [regs];
    vec_t  v_regs [regs];

    // combinational read ports
    assign s_rs1 = s_regs[rs1];
    assign s_rs2 = s_regs[rs2];
    assign v_rs1 = v_regs[rs1];
    assign v_rs2 = v_regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regs; i++) begin
                s_regs[i] <= '0;
                v_regs[i] <= '0;
            end
        end else begin
            if (s_we)
                s_regs[wr_idx] <= s_wdata;
            // masked lanes keep their old value
            if (v_we) begin
                for (int l = 0; l < lanes; l++) begin
                    if (v_lane_mask[l])
                        v_regs[wr_idx][l] <= v_wdata[l];
                end
            end
        end
    end

endmodule

// File: verilog/vcore_pkg.sv
package vcore_pkg;

    // datapath widths
    localparam int word_w     = 16;
    localparam int lanes      = 4;
    localparam int reg_idx_w  = 3;
    // address field width in the memory request, modules use the low addr_w bits
    localparam int mem_addr_w = 8;

    typedef logic [word_w-1:0] word_t;
    typedef logic [lanes-1:0][word_w-1:0] vec_t;

    // opcode map
    localparam logic [5:0] op_vv_add   = 6'b000000;
    localparam logic [5:0] op_vv_sub   = 6'b000001;
    localparam logic [5:0] op_vf_add   = 6'b001000;
    localparam logic [5:0] op_vf_sub   = 6'b001001;
    localparam logic [5:0] op_int_addi = 6'b001100;
    localparam logic [5:0] op_int_add  = 6'b011000;
    localparam logic [5:0] op_int_sub  = 6'b011001;
    localparam logic [5:0] op_reduce   = 6'b100100;
    localparam logic [5:0] op_lane_get = 6'b100101;
    localparam logic [5:0] op_lane_put = 6'b100111;
    // bit 4 is write, bit 1 is vector
    localparam logic [5:0] op_load_s   = 6'b101100;
    localparam logic [5:0] op_load_v   = 6'b101110;
    localparam logic [5:0] op_store_s  = 6'b111100;
    localparam logic [5:0] op_store_v  = 6'b111110;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [1:0]           imm;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
    } instr_t;

    typedef struct packed {
        logic            int_en;
        logic            int_op2_sel;
        logic [3:0]      lane_en;
        logic [3:0]      lane_op1_sel;
        // lanes 0 and 2, then lanes 1 and 3
        logic [1:0][1:0] lane_even_op2_sel;
        logic [1:0]      lane_odd_op2_sel;
        logic [2:0]      scalar_out_sel;
        logic [2:0]      memory_op;
        logic            reduce_en;
        logic            sub;
        logic            s_we;
        logic            v_we;
    } ctrl_t;

    typedef struct packed {
        logic                  we;
        logic [mem_addr_w-1:0] addr;
        vec_t                  wdata;
        logic [lanes-1:0]      mask;
    } mem_req_t;

    typedef struct packed {
        vec_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                 is_vector;
        logic [reg_idx_w-1:0] rd;
        word_t                scalar;
        vec_t                 vector;
    } result_t;

    // load and store classes 1011 and 1111
    function automatic logic is_mem_op(logic [5:0] opcode);
        return opcode[5] & opcode[3] & opcode[2];
    endfunction

endpackage

// File: verilog/vcore_top.sv
`timescale 1ns/100ps

module vcore_top #(
    parameter int addr_w = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    output logic                instr_ready,
    input  vcore_pkg::instr_t   instr,
    output logic                result_valid,
    input  logic                result_ready,
    output vcore_pkg::result_t  result,
    input  logic                host_valid,
    output logic                host_ready,
    input  vcore_pkg::mem_req_t host_req,
    output logic                host_rsp_valid,
    output vcore_pkg::mem_rsp_t host_rsp
);
    import vcore_pkg::*;

    instr_t     held_instr;
    ctrl_t      ctrl;
    word_t      s_rs1;
    word_t      s_rs2;
    word_t      scalar_result;
    word_t      s_wdata;
    vec_t       v_rs1;
    vec_t       v_rs2;
    vec_t       vector_result;
    vec_t       v_wdata;
    logic [3:0] lane_mask;
    logic [3:0] v_lane_mask;
    logic       s_we;
    logic       v_we;
    logic [2:0] wr_idx;
    logic       core_valid;
    logic       core_ready;
    logic       core_rsp_valid;
    mem_req_t   core_req;
    mem_rsp_t   core_rsp;
    logic       mem_en;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rdata;

    instruction_decode_unit u_decode (
        .instr (held_instr),
        .ctrl  (ctrl)
    );

    register_files u_regs (
        .clk         (clk),
        .reset       (reset),
        .rs1         (held_instr.rs1),
        .rs2         (held_instr.rs2),
        .s_we        (s_we),
        .v_we        (v_we),
        .wr_idx      (wr_idx),
        .s_wdata     (s_wdata),
        .v_wdata     (v_wdata),
        .v_lane_mask (v_lane_mask),
        .s_rs1       (s_rs1),
        .s_rs2       (s_rs2),
        .v_rs1       (v_rs1),
        .v_rs2       (v_rs2)
    );

    execute_lanes u_exec (
        .ctrl          (ctrl),
        .imm           (held_instr.imm),
        .rs2           (held_instr.rs2),
        .s_rs1         (s_rs1),
        .s_rs2         (s_rs2),
        .v_rs1         (v_rs1),
        .v_rs2         (v_rs2),
        .scalar_result (scalar_result),
        .vector_result (vector_result),
        .lane_mask     (lane_mask)
    );

    issue_sequencer #(.addr_w(addr_w)) u_seq (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .ctrl           (ctrl),
        .scalar_result  (scalar_result),
        .vector_result  (vector_result),
        .lane_mask      (lane_mask),
        .s_rs1          (s_rs1),
        .s_rs2          (s_rs2),
        .v_rs2          (v_rs2),
        .core_ready     (core_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .result_ready   (result_ready),
        .instr_ready    (instr_ready),
        .held_instr     (held_instr),
        .core_valid     (core_valid),
        .core_req       (core_req),
        .s_we           (s_we),
        .v_we           (v_we),
        .wr_idx         (wr_idx),
        .s_wdata        (s_wdata),
        .v_wdata        (v_wdata),
        .v_lane_mask    (v_lane_mask),
        .result_valid   (result_valid),
        .result         (result)
    );

    mem_arbiter #(.addr_w(addr_w)) u_arb (
        .clk            (clk),
        .reset          (reset),
        .core_valid     (core_valid),
        .core_req       (core_req),
        .host_valid     (host_valid),
        .host_req       (host_req),
        .core_ready     (core_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .host_ready     (host_ready),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp       (host_rsp),
        .mem_en         (mem_en),
        .mem_req        (mem_req),
        .mem_rdata      (mem_rdata)
    );

    data_memory #(.addr_w(addr_w)) u_mem (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule
